/* logic/lsq_macros.svh */
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// queue sizing
`define LSQ_DEPTH 16
`define LSQ_IDX_BITS 4

// data ram, word address bits
`define DMEM_WORDS_LOG2 8

`endif

/* logic/lsq_pkg.sv */
`default_nettype none

`include "lsq_macros.svh"

package lsq_pkg;

    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // shared by loads and stores
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_fmt_t;

    // loads decode as I, stores as S
    typedef union packed {
        i_fmt_t i;
        s_fmt_t s;
    } inst_u;

    typedef struct packed {
        inst_u       inst;
        logic [5:0]  pd;
        logic [4:0]  rd;
        logic [5:0]  rob;
    } dispatch_t;

    typedef struct packed {
        logic [`LSQ_IDX_BITS-1:0] idx;
        inst_u                    inst;
        logic [31:0]              rs1_data;
        logic [31:0]              rs2_data;
    } agu_issue_t;

    typedef struct packed {
        logic [`LSQ_IDX_BITS-1:0] idx;
        logic [31:0]              addr;
        logic [31:0]              store_data;
    } agu_result_t;

    typedef struct packed {
        logic        valid;
        logic        addr_ready;
        dispatch_t   disp;
        logic [31:0] addr;
        logic [31:0] store_data;
    } lsq_entry_t;

    typedef struct packed {
        logic [31:0] addr;     // word aligned
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic        valid;
        logic [5:0]  rob_idx;
        logic [5:0]  pd;
        logic [4:0]  rd;
        logic [31:0] value;
        logic [31:0] addr;     // byte address
        logic [3:0]  rmask;
        logic [3:0]  wmask;
    } cdb_t;

endpackage

`default_nettype wire

/* logic/address_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module address_gen (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               issue_valid,
    input  wire lsq_pkg::agu_issue_t issue,
    output logic                    res_valid,
    output lsq_pkg::agu_result_t    res
);

    logic [31:0] imm;
    logic [31:0] sum;

    // immediate layout depends on load vs store
    always_comb begin
        if (issue.inst.s.opcode == lsq_pkg::op_store) begin
            imm = {{20{issue.inst.s.imm_hi[6]}}, issue.inst.s.imm_hi, issue.inst.s.imm_lo};
        end else begin
            imm = {{20{issue.inst.i.imm[11]}}, issue.inst.i.imm};
        end
    end

    assign sum = issue.rs1_data + imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res.idx        <= issue.idx;
            res.addr       <= sum;
            res.store_data <= issue.rs2_data;   // only meaningful for stores
        end
    end

endmodule

`default_nettype wire

/* logic/memory_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module memory_queue #(
    parameter int QUEUE_DEPTH = `LSQ_DEPTH
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // dispatch side
    input  wire logic                 dispatch_valid,
    input  wire lsq_pkg::dispatch_t   dispatch,

    // address generator
    input  wire logic                 agu_valid,
    input  wire lsq_pkg::agu_result_t agu_res,

    input  wire logic [5:0]           commit_rob,

    // data ram response
    input  wire logic [31:0]          dmem_rdata,
    input  wire logic                 dmem_valid,

    output logic                      full,
    output logic [`LSQ_IDX_BITS-1:0]  mem_idx,
    output lsq_pkg::dmem_req_t        dmem_req,
    output lsq_pkg::cdb_t             cdb
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    lsq_pkg::lsq_entry_t q [QUEUE_DEPTH];
    lsq_pkg::lsq_entry_t head_ent;

    logic [IDX_W:0]   head;   // msb is the wrap bit
    logic [IDX_W:0]   tail;
    logic [IDX_W-1:0] head_slot;
    logic [IDX_W-1:0] tail_slot;

    logic             enq;
    logic             deq;
    logic             head_ready;
    logic             is_load;
    logic             is_store;
    logic             committed;

    logic [2:0]       funct3;
    logic [1:0]       offset;
    logic [3:0]       size_mask;
    logic [3:0]       lane_mask;

    logic [7:0]       byte_sel;
    logic [15:0]      half_sel;
    logic [31:0]      load_val;

    assign head_slot = head[IDX_W-1:0];
    assign tail_slot = tail[IDX_W-1:0];
    assign head_ent  = q[head_slot];

    assign full    = (head_slot == tail_slot) && (head[IDX_W] != tail[IDX_W]);
    assign mem_idx = `LSQ_IDX_BITS'(tail_slot);

    // a response only ever belongs to the head
    assign deq = dmem_valid;
    assign enq = dispatch_valid && (!full || deq);

    assign funct3     = head_ent.disp.inst.i.funct3;
    assign offset     = head_ent.addr[1:0];
    assign head_ready = head_ent.valid && head_ent.addr_ready;
    assign is_load    = head_ent.disp.inst.i.opcode == lsq_pkg::op_load;
    assign is_store   = head_ent.disp.inst.s.opcode == lsq_pkg::op_store;
    assign committed  = head_ent.disp.rob == commit_rob;

    always_comb begin
        case (funct3)
            lsq_pkg::f3_b, lsq_pkg::f3_bu: size_mask = 4'b0001;
            lsq_pkg::f3_h, lsq_pkg::f3_hu: size_mask = 4'b0011;
            default:                       size_mask = 4'b1111;
        endcase
        lane_mask = size_mask << offset;
    end

    // head request, stores held back until the rob lets them go
    always_comb begin
        dmem_req.addr  = {head_ent.addr[31:2], 2'b00};
        dmem_req.rmask = (head_ready && is_load) ? lane_mask : 4'b0000;
        dmem_req.wmask = (head_ready && is_store && committed) ? lane_mask : 4'b0000;
        dmem_req.wdata = head_ent.store_data << {offset, 3'b000};
    end

    assign byte_sel = dmem_rdata[8*offset +: 8];
    assign half_sel = dmem_rdata[16*offset[1] +: 16];

    always_comb begin
        case (funct3)
            lsq_pkg::f3_b:  load_val = {{24{byte_sel[7]}}, byte_sel};
            lsq_pkg::f3_bu: load_val = {24'b0, byte_sel};
            lsq_pkg::f3_h:  load_val = {{16{half_sel[15]}}, half_sel};
            lsq_pkg::f3_hu: load_val = {16'b0, half_sel};
            default:        load_val = dmem_rdata;
        endcase
    end

    always_comb begin
        cdb = '0;
        if (dmem_valid) begin
            cdb.valid   = 1'b1;
            cdb.rob_idx = head_ent.disp.rob;
            cdb.pd      = head_ent.disp.pd;
            cdb.rd      = head_ent.disp.rd;
            cdb.value   = is_load ? load_val : 32'b0;  // stores carry no result
            cdb.addr    = head_ent.addr;
            cdb.rmask   = is_load ? lane_mask : 4'b0000;
            cdb.wmask   = is_store ? lane_mask : 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                q[i].valid      <= 1'b0;
                q[i].addr_ready <= 1'b0;
            end
        end else begin
            // addresses come back in any slot order
            if (agu_valid) begin
                q[agu_res.idx].addr_ready <= 1'b1;
                q[agu_res.idx].addr       <= agu_res.addr;
                q[agu_res.idx].store_data <= agu_res.store_data;
            end

            if (deq) begin
                q[head_slot].valid      <= 1'b0;
                q[head_slot].addr_ready <= 1'b0;
                head                    <= head + 1'b1;
            end

            // last so a refill of the freed slot wins when full
            if (enq) begin
                q[tail_slot].valid      <= 1'b1;
                q[tail_slot].addr_ready <= 1'b0;
                q[tail_slot].disp       <= dispatch;
                tail                    <= tail + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module data_ram (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire lsq_pkg::dmem_req_t req,
    output logic [31:0]             rdata,
    output logic                    valid
);

    localparam int WORDS = 1 << `DMEM_WORDS_LOG2;

    logic [31:0]                  mem [WORDS];
    logic [`DMEM_WORDS_LOG2-1:0]  word;
    logic                         busy;
    logic                         start;

    assign word = req.addr[`DMEM_WORDS_LOG2+1:2];

    // request stays up through the response cycle, don't take it twice
    assign start = !busy && (|req.rmask || |req.wmask);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= start;
        end
    end

    assign valid = busy;   // one pulse per access

    always_ff @(posedge clk) begin
        if (start) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wmask[b]) begin
                    mem[word][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
            rdata <= mem[word];
        end
    end

endmodule

`default_nettype wire

/* logic/mem_backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module mem_backend_top (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire logic                 dispatch_valid,
    input  wire lsq_pkg::dispatch_t   dispatch,

    input  wire logic                 issue_valid,
    input  wire lsq_pkg::agu_issue_t  issue,

    input  wire logic [5:0]           commit_rob,

    output logic                      full,
    output logic [`LSQ_IDX_BITS-1:0]  mem_idx,
    output lsq_pkg::cdb_t             cdb
);

    logic                 agu_res_valid;
    lsq_pkg::agu_result_t agu_res;

    lsq_pkg::dmem_req_t   dmem_req;
    logic [31:0]          dmem_rdata;
    logic                 dmem_valid;

    address_gen u_address_gen (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .res_valid   (agu_res_valid),
        .res         (agu_res)
    );

    memory_queue #(
        .QUEUE_DEPTH (`LSQ_DEPTH)
    ) u_memory_queue (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .agu_valid      (agu_res_valid),
        .agu_res        (agu_res),
        .commit_rob     (commit_rob),
        .dmem_rdata     (dmem_rdata),
        .dmem_valid     (dmem_valid),
        .full           (full),
        .mem_idx        (mem_idx),
        .dmem_req       (dmem_req),
        .cdb            (cdb)
    );

    // stands in for the data cache
    data_ram u_data_ram (
        .clk   (clk),
        .rst   (rst),
        .req   (dmem_req),
        .rdata (dmem_rdata),
        .valid (dmem_valid)
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;   // 50 percent duty

endmodule

`default_nettype wire

/* sim/mem_backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module mem_backend_tb #(
    parameter int unsigned SEED = 89590
);

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] BASE       = 32'h0000_0100;

    typedef struct packed {
        logic [6:0]               op;
        logic [2:0]               f3;
        logic [31:0]              addr;
        logic [31:0]              data;
        logic [11:0]              imm;
        logic [5:0]               rob;
        logic [`LSQ_IDX_BITS-1:0] idx;
    } mem_op_t;

    logic                     clk;
    logic                     rst;
    logic                     dispatch_valid;
    lsq_pkg::dispatch_t       dispatch;
    logic                     issue_valid;
    lsq_pkg::agu_issue_t      issue;
    logic [5:0]               commit_rob;
    logic                     full;
    logic [`LSQ_IDX_BITS-1:0] mem_idx;
    lsq_pkg::cdb_t            cdb;

    logic [7:0]               model [0:1023];   // byte image of the ram
    lsq_pkg::cdb_t            expected [$];     // in dispatch order
    mem_op_t                  batch [$];
    int                       done_count;
    logic [5:0]               next_rob;
    logic [`LSQ_IDX_BITS-1:0] next_idx;

    tb_clock #(.PERIOD_NS(20)) u_tb_clock (.clk(clk));

    mem_backend_top u_mem_backend_top (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .commit_rob     (commit_rob),
        .full           (full),
        .mem_idx        (mem_idx),
        .cdb            (cdb)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
            else fail_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> (!cdb.valid && !full && mem_idx == '0))
        else fail_run("bus, full or slot index not cleared by reset");

    store_after_commit: assert property (@(posedge clk) disable iff (rst)
        (cdb.valid && cdb.wmask != 4'b0000) |-> (cdb.rob_idx == commit_rob))
        else fail_run("a store completed while commit named another rob entry");

    one_kind: assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> ((cdb.rmask != 4'b0000) ^ (cdb.wmask != 4'b0000)))
        else fail_run("completion carries neither or both of the masks");

    drop_when_full: assert property (@(posedge clk) disable iff (rst)
        (full && !cdb.valid) |=> $stable(mem_idx))
        else fail_run("queue took a dispatch while full");

    function automatic logic [3:0] lane_mask_for(input logic [2:0] f3, input logic [1:0] off);
        case (f3)
            lsq_pkg::f3_b, lsq_pkg::f3_bu: return 4'b0001 << off;
            lsq_pkg::f3_h, lsq_pkg::f3_hu: return 4'b0011 << off;
            default:                       return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] load_result(input logic [2:0] f3, input logic [9:0] a);
        logic [7:0]  b0;
        logic [15:0] h0;
        b0 = model[a];
        h0 = {model[a + 10'd1], b0};
        case (f3)
            lsq_pkg::f3_b:  return {{24{b0[7]}}, b0};
            lsq_pkg::f3_bu: return {24'b0, b0};
            lsq_pkg::f3_h:  return {{16{h0[15]}}, h0};
            lsq_pkg::f3_hu: return {16'b0, h0};
            default:        return {model[a + 10'd3], model[a + 10'd2], h0};
        endcase
    endfunction

    function automatic lsq_pkg::inst_u make_inst(input mem_op_t m);
        lsq_pkg::inst_u inst;
        if (m.op == lsq_pkg::op_store) begin
            inst.s.imm_hi = m.imm[11:5];
            inst.s.rs2    = 5'd2;
            inst.s.rs1    = 5'd1;
            inst.s.funct3 = m.f3;
            inst.s.imm_lo = m.imm[4:0];
            inst.s.opcode = m.op;
        end else begin
            inst.i.imm    = m.imm;
            inst.i.rs1    = 5'd1;
            inst.i.funct3 = m.f3;
            inst.i.rd     = m.rob[4:0];
            inst.i.opcode = m.op;
        end
        return inst;
    endfunction

    // aligned access somewhere in an 8 word window
    function automatic mem_op_t random_op(input logic [6:0] op, input logic [2:0] f3);
        mem_op_t    m;
        logic [1:0] off;
        m = '0;
        case (f3)
            lsq_pkg::f3_b, lsq_pkg::f3_bu: off = 2'($urandom_range(0, 3));
            lsq_pkg::f3_h, lsq_pkg::f3_hu: off = 2'(2 * $urandom_range(0, 1));
            default:                       off = 2'b00;
        endcase
        m.op   = op;
        m.f3   = f3;
        m.addr = BASE + 32'(4 * $urandom_range(0, 7)) + 32'(off);
        m.data = $urandom;
        m.imm  = 12'($urandom_range(0, 4095));
        return m;
    endfunction

    always @(negedge clk) begin : completion_monitor
        lsq_pkg::cdb_t exp;
        if (!rst && cdb.valid) begin
            if (expected.size() == 0) begin
                fail_run($sformatf("completion for rob %0d with nothing pending", cdb.rob_idx));
            end else begin
                exp = expected.pop_front();
                check_value("cdb rob_idx", 32'(exp.rob_idx), 32'(cdb.rob_idx));
                check_value("cdb pd", 32'(exp.pd), 32'(cdb.pd));
                check_value("cdb rd", 32'(exp.rd), 32'(cdb.rd));
                check_value("cdb addr", exp.addr, cdb.addr);
                check_value("cdb rmask", 32'(exp.rmask), 32'(cdb.rmask));
                check_value("cdb wmask", 32'(exp.wmask), 32'(cdb.wmask));
                if (exp.rmask != 4'b0000) begin
                    check_value("load value", exp.value, cdb.value);
                end
                done_count++;
            end
        end
    end

    task automatic dispatch_op(inout mem_op_t m, input bit accepted);
        lsq_pkg::cdb_t      exp;
        lsq_pkg::dispatch_t d;
        @(negedge clk);
        check_value("mem_idx before dispatch", 32'(next_idx), 32'(mem_idx));
        m.idx  = mem_idx;
        m.rob  = next_rob;
        d.inst = make_inst(m);
        d.pd   = m.rob ^ 6'h2a;
        d.rd   = (m.op == lsq_pkg::op_load) ? m.rob[4:0] : 5'd0;
        d.rob  = m.rob;
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch       <= d;
        @(posedge clk);
        dispatch_valid <= 1'b0;
        next_rob++;
        if (accepted) begin
            exp         = '0;
            exp.valid   = 1'b1;
            exp.rob_idx = d.rob;
            exp.pd      = d.pd;
            exp.rd      = d.rd;
            exp.addr    = m.addr;
            if (m.op == lsq_pkg::op_load) begin
                exp.rmask = lane_mask_for(m.f3, m.addr[1:0]);
                exp.value = load_result(m.f3, m.addr[9:0]);
            end else begin
                exp.wmask = lane_mask_for(m.f3, m.addr[1:0]);
                for (int b = 0; b < 4; b++) begin
                    if (b < $countones(exp.wmask)) model[m.addr[9:0] + 10'(b)] = m.data[8*b +: 8];
                end
            end
            expected.push_back(exp);
            next_idx++;
        end
    endtask

    task automatic issue_batch();
        lsq_pkg::agu_issue_t iss;
        foreach (batch[k]) begin
            iss.idx      = batch[k].idx;
            iss.inst     = make_inst(batch[k]);
            iss.rs1_data = batch[k].addr - {{20{batch[k].imm[11]}}, batch[k].imm};
            iss.rs2_data = batch[k].data;
            @(posedge clk);
            issue_valid <= 1'b1;
            issue       <= iss;
        end
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic wait_done(input int target, input string what);
        int n;
        n = 0;
        while (done_count < target && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (done_count < target) fail_run($sformatf("timed out waiting for %s", what));
    endtask

    task automatic run_serial(input mem_op_t op_in);
        mem_op_t m;
        int      target;
        m      = op_in;
        target = done_count + 1;
        dispatch_op(m, 1'b1);
        batch.delete();
        batch.push_back(m);
        issue_batch();
        if (m.op == lsq_pkg::op_store) begin
            @(posedge clk);
            commit_rob <= m.rob;
        end
        wait_done(target, "serial access");
    endtask

    task automatic check_reset_outputs(input string when);
        check_value({when, " cdb.valid"}, 32'd0, 32'(cdb.valid));
        check_value({when, " full"}, 32'd0, 32'(full));
        check_value({when, " mem_idx"}, 32'd0, 32'(mem_idx));
    endtask

    initial begin : stimulus
        mem_op_t m;
        mem_op_t tmp;
        mem_op_t group [$];
        logic [2:0] f3s [5];
        int target;
        int j;
        void'($urandom(SEED));
        f3s            = '{lsq_pkg::f3_b, lsq_pkg::f3_h, lsq_pkg::f3_w,
                           lsq_pkg::f3_bu, lsq_pkg::f3_hu};
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        issue_valid    = 1'b0;
        issue          = '0;
        commit_rob     = '0;
        done_count     = 0;
        next_rob       = '0;
        next_idx       = '0;

        @(negedge clk);
        check_reset_outputs("during reset");
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_reset_outputs("after reset");

        // fill the window, then mixed stores, then every load width
        for (int w = 0; w < 8; w++) begin
            m      = random_op(lsq_pkg::op_store, lsq_pkg::f3_w);
            m.addr = BASE + 32'(4 * w);
            run_serial(m);
        end
        for (int s = 0; s < 12; s++) begin
            run_serial(random_op(lsq_pkg::op_store, f3s[$urandom_range(0, 2)]));
        end
        foreach (f3s[k]) begin
            for (int r = 0; r < 3; r++) run_serial(random_op(lsq_pkg::op_load, f3s[k]));
        end

        // store at the head stays put until committed
        m      = random_op(lsq_pkg::op_store, lsq_pkg::f3_w);
        target = done_count + 1;
        @(posedge clk);
        commit_rob <= next_rob ^ 6'h20;
        dispatch_op(m, 1'b1);
        batch.delete();
        batch.push_back(m);
        issue_batch();
        for (int c = 0; c < 8; c++) @(posedge clk);
        check_value("store held before commit", 32'(target - 1), 32'(done_count));
        commit_rob <= m.rob;
        wait_done(target, "committed store");

        // completions stay in order under shuffled address issue
        group.delete();
        target = done_count + 8;
        for (int l = 0; l < 8; l++) begin
            m = random_op(lsq_pkg::op_load, f3s[$urandom_range(0, 4)]);
            dispatch_op(m, 1'b1);
            group.push_back(m);
        end
        batch = group;
        for (int i = batch.size() - 1; i > 0; i--) begin
            j        = $urandom_range(0, i);
            tmp      = batch[i];
            batch[i] = batch[j];
            batch[j] = tmp;
        end
        issue_batch();
        wait_done(target, "shuffled loads");

        // fill every slot with no address known
        group.delete();
        target = done_count;
        for (int l = 0; l < `LSQ_DEPTH; l++) begin
            m = random_op(lsq_pkg::op_load, lsq_pkg::f3_w);
            dispatch_op(m, 1'b1);
            group.push_back(m);
            @(negedge clk);
            check_value("full while filling", 32'(l == `LSQ_DEPTH - 1), 32'(full));
        end
        m = random_op(lsq_pkg::op_load, lsq_pkg::f3_w);
        dispatch_op(m, 1'b0);
        @(negedge clk);
        check_value("full after dropped dispatch", 32'd1, 32'(full));
        check_value("mem_idx after dropped dispatch", 32'(next_idx), 32'(mem_idx));
        batch.delete();
        batch.push_back(group.pop_front());
        issue_batch();
        wait_done(target + 1, "head of full queue");
        @(negedge clk);
        check_value("full after one completion", 32'd0, 32'(full));
        batch = group;
        issue_batch();
        wait_done(target + `LSQ_DEPTH, "rest of full queue");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+logic
logic/lsq_pkg.sv
logic/address_gen.sv
logic/memory_queue.sv
logic/data_ram.sv
logic/mem_backend_top.sv
sim/tb_clock.sv
sim/mem_backend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_backend_tb
RTL_TOP   ?= mem_backend_top
SEED      ?= 89590
BUILD_DIR ?= build
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

# the simulator exits nonzero on $fatal, so make fails with it
run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
